//--- list.f
hw/tpmMgmtPkg.sv
hw/lifecycleFsm.sv
hw/startupCounters.sv
hw/restorePolicy.sv
hw/tpmManagement.sv
tests/clockGen.sv
tests/tpmManagementTb.sv

//--- Bender.yml
package:
  name: tpmManagement

sources:
  - files:
      - hw/tpmMgmtPkg.sv
      - hw/lifecycleFsm.sv
      - hw/startupCounters.sv
      - hw/restorePolicy.sv
      - hw/tpmManagement.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/tpmManagementTb.sv

//--- tests/tpmManagementTb.sv
// directed tests of the TPM manager with typed compare tasks and a closing summary
`default_nettype none

module tpmManagementTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned counterWidth = 32;
	localparam tpmMgmtPkg::testCountT fullTestCount = 16'd40;
	localparam int timeoutCycles = 64;

	typedef logic [counterWidth-1:0] countT;

	localparam tpmMgmtPkg::restoreSelectT allPreserved = '{platformAuth: 1'b1, nvIndex: 1'b1,
		pcrSave: tpmMgmtPkg::fullPreserved, contextArray: 1'b1, audit: 1'b1, commit: 1'b1,
		act: 1'b1, regenerateSecrets: 1'b0};
	localparam tpmMgmtPkg::restoreSelectT resetSelects = '{platformAuth: 1'b0, nvIndex: 1'b0,
		pcrSave: tpmMgmtPkg::fullDefault, contextArray: 1'b0, audit: 1'b0, commit: 1'b0,
		act: 1'b0, regenerateSecrets: 1'b1};
	localparam tpmMgmtPkg::restoreSelectT restartSelects = '{platformAuth: 1'b0, nvIndex: 1'b0,
		pcrSave: tpmMgmtPkg::fullDefault, contextArray: 1'b1, audit: 1'b1, commit: 1'b1,
		act: 1'b0, regenerateSecrets: 1'b0};
	localparam tpmMgmtPkg::restoreSelectT resumeSelects = '{platformAuth: 1'b1, nvIndex: 1'b1,
		pcrSave: tpmMgmtPkg::psPreserved, contextArray: 1'b1, audit: 1'b1, commit: 1'b1,
		act: 1'b1, regenerateSecrets: 1'b0};

	logic clock, reset_n, resetRequest;
	tpmMgmtPkg::commandT command;
	logic commandValid, orderlyAtPowerOn, restoreOk;
	tpmMgmtPkg::selfTestStatusT selfTest;
	logic commandReady, shutdownSave, initialized;
	tpmMgmtPkg::opStateT opState;
	countT resetCount, restartCount, clearCount;
	tpmMgmtPkg::hierarchyT hierarchy;
	tpmMgmtPkg::restoreSelectT selects;

	integer seed = 17228;
	int errorCount = 0;
	int testErrors = 0; // errorCount when the running test began
	int passCount = 0;
	int failCount = 0;

	clockGen clocks (.resetRequest(resetRequest), .clock(clock), .reset_n(reset_n));

	tpmManagement #(.counterWidth(counterWidth), .fullTestCount(fullTestCount)) dut (.*);

	task automatic checkState(input string name, input tpmMgmtPkg::opStateT expected,
			input tpmMgmtPkg::opStateT actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %s, got %s (%0d)", $time, name,
				expected.name(), actual.name(), actual);
			errorCount++;
		end
	endtask

	task automatic checkCount(input string name, input countT expected, input countT actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name,
				expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkHierarchy(input string name, input tpmMgmtPkg::hierarchyT expected,
			input tpmMgmtPkg::hierarchyT actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name,
				expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkSelects(input string name, input tpmMgmtPkg::restoreSelectT expected,
			input tpmMgmtPkg::restoreSelectT actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name,
				expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name,
				expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkCounters(input countT resets, input countT restarts, input countT clears);
		checkCount("resetCount", resets, resetCount);
		checkCount("restartCount", restarts, restartCount);
		checkCount("clearCount", clears, clearCount);
	endtask

	task automatic endTest(input string name);
		if (errorCount == testErrors) begin
			$display("test %s: ok", name);
			passCount++;
		end else begin
			$display("test %s: FAILED with %0d errors", name, errorCount - testErrors);
			failCount++;
		end
		testErrors = errorCount;
	endtask

	function automatic logic isLifecycle(input tpmMgmtPkg::commandCodeT code);
		return code == tpmMgmtPkg::ccStartup || code == tpmMgmtPkg::ccShutdown ||
			code == tpmMgmtPkg::ccSelfTest || code == tpmMgmtPkg::ccIncrementalSelfTest;
	endfunction

	// holds valid until ready, returns on the falling edge after the transfer
	task automatic sendCommand(input tpmMgmtPkg::commandCodeT code, input logic param);
		int waited;
		waited = 0;
		command = '{code: code, param: param};
		commandValid = 1'b1;
		while (commandReady !== 1'b1 && waited < timeoutCycles) begin
			@(negedge clock);
			waited++;
		end
		if (commandReady !== 1'b1) begin
			$display("ERROR at %0t ns: commandReady never rose for code %h", $time, code);
			errorCount++;
		end
		@(negedge clock);
		commandValid = 1'b0;
	endtask

	task automatic waitLeave(input tpmMgmtPkg::opStateT from);
		int waited;
		waited = 0;
		while (opState == from && waited < timeoutCycles) begin
			@(negedge clock);
			waited++;
		end
		if (opState == from) begin
			$display("ERROR at %0t ns: opState never left %s", $time, from.name());
			errorCount++;
		end
	endtask

	// ends in the first initialization cycle
	task automatic powerUp();
		int waited;
		waited = 0;
		while (reset_n !== 1'b1 && waited < timeoutCycles) begin
			@(negedge clock);
			waited++;
		end
		if (reset_n !== 1'b1) begin
			$display("ERROR at %0t ns: reset_n was never released", $time);
			errorCount++;
		end
		checkState("opState", tpmMgmtPkg::powerOff, opState);
		@(negedge clock);
		checkState("opState", tpmMgmtPkg::initialization, opState);
	endtask

	task automatic applyReset(input logic orderly);
		int waited;
		waited = 0;
		orderlyAtPowerOn = orderly; // sampled in powerOff
		resetRequest = 1'b1;
		while (reset_n !== 1'b0 && waited < timeoutCycles) begin
			@(negedge clock);
			waited++;
		end
		if (reset_n !== 1'b0) begin
			$display("ERROR at %0t ns: reset request was not answered", $time);
			errorCount++;
		end
		resetRequest = 1'b0;
		powerUp();
	endtask

	// ends one edge after startup, when the outcome is visible
	task automatic startupTo(input logic suType);
		sendCommand(tpmMgmtPkg::ccStartup, suType);
		checkState("opState", tpmMgmtPkg::startup, opState);
		@(negedge clock);
	endtask

	task automatic resetTest();
		powerUp();
		checkBit("commandReady", 1'b1, commandReady);
		checkCounters(0, 0, 0);
		checkHierarchy("hierarchy", 4'b0000, hierarchy);
		checkBit("initialized", 1'b0, initialized);
		checkBit("shutdownSave", 1'b0, shutdownSave);
		checkSelects("selects", allPreserved, selects);
		endTest("reset state");
	endtask

	task automatic coldStartupTest();
		startupTo(tpmMgmtPkg::suState); // not orderly, so no resume
		checkState("opState", tpmMgmtPkg::initialization, opState);
		checkCounters(0, 0, 0);
		checkBit("initialized", 1'b0, initialized);
		startupTo(tpmMgmtPkg::suClear);
		checkState("opState", tpmMgmtPkg::operational, opState);
		checkCounters(1, 0, 0);
		checkHierarchy("hierarchy", 4'b1111, hierarchy);
		checkSelects("selects", resetSelects, selects);
		checkBit("initialized", 1'b1, initialized);
		@(negedge clock);
		checkBit("regenerateSecrets", 1'b0, selects.regenerateSecrets); // single pulse
		endTest("cold startup");
	endtask

	task automatic shutdownTrafficTest();
		tpmMgmtPkg::commandCodeT code;
		// SU_STATE first, so the SU_CLEAR record has to overwrite it
		for (int p = 1; p >= 0; p--) begin
			sendCommand(tpmMgmtPkg::ccShutdown, p[0]);
			checkState("opState", tpmMgmtPkg::shutdown, opState);
			@(negedge clock);
			checkState("opState", tpmMgmtPkg::operational, opState);
			checkBit("shutdownSave", p[0], shutdownSave);
		end
		repeat (8) begin
			code = $random(seed);
			if (isLifecycle(code))
				code[20] = ~code[20];
			sendCommand(code, code[0]);
			checkState("opState", tpmMgmtPkg::operational, opState);
			checkCounters(1, 0, 0);
		end
		endTest("shutdown and traffic");
	endtask

	task automatic selfTestTest();
		selfTest = '{testsRun: fullTestCount, testsPassed: fullTestCount, untested: 16'd7};
		sendCommand(tpmMgmtPkg::ccSelfTest, 1'b1);
		waitLeave(tpmMgmtPkg::selfTest);
		checkState("opState", tpmMgmtPkg::operational, opState);
		selfTest = '{testsRun: 16'd12, testsPassed: 16'd12, untested: 16'd3};
		sendCommand(tpmMgmtPkg::ccIncrementalSelfTest, 1'b0);
		repeat (4) begin
			checkState("opState", tpmMgmtPkg::selfTest, opState);
			@(negedge clock);
		end
		selfTest.untested = '0;
		waitLeave(tpmMgmtPkg::selfTest);
		checkState("opState", tpmMgmtPkg::operational, opState);
		selfTest = '{testsRun: 16'd12, testsPassed: 16'd11, untested: 16'd0};
		sendCommand(tpmMgmtPkg::ccSelfTest, 1'b1);
		waitLeave(tpmMgmtPkg::selfTest);
		checkState("opState", tpmMgmtPkg::failureMode, opState);
		endTest("self-test");
	endtask

	task automatic orderlyTest();
		applyReset(1'b1);
		startupTo(tpmMgmtPkg::suClear);
		checkState("opState", tpmMgmtPkg::operational, opState);
		checkCounters(0, 1, 1);
		checkHierarchy("hierarchy", 4'b1111, hierarchy);
		checkSelects("selects", restartSelects, selects);
		applyReset(1'b1);
		restoreOk = 1'b1;
		startupTo(tpmMgmtPkg::suState);
		checkState("opState", tpmMgmtPkg::operational, opState);
		checkCounters(0, 1, 0);
		checkHierarchy("hierarchy", 4'b1000, hierarchy); // platform only
		checkSelects("selects", resumeSelects, selects);
		endTest("orderly startup");
	endtask

	task automatic failedRestoreTest();
		logic [31:0] rnd;
		tpmMgmtPkg::commandCodeT code;
		applyReset(1'b1);
		restoreOk = 1'b0;
		startupTo(tpmMgmtPkg::suState);
		checkState("opState", tpmMgmtPkg::failureMode, opState);
		checkCounters(0, 0, 0);
		checkBit("initialized", 1'b0, initialized);
		repeat (8) begin
			rnd = $random(seed);
			code = rnd[2] ? tpmMgmtPkg::ccIncrementalSelfTest + rnd[1:0] : rnd;
			sendCommand(code, rnd[31]);
			checkState("opState", tpmMgmtPkg::failureMode, opState);
			checkBit("commandReady", 1'b1, commandReady);
		end
		endTest("failed restore");
	endtask

	initial begin
		resetRequest = 1'b0;
		command = '0;
		commandValid = 1'b0;
		orderlyAtPowerOn = 1'b0;
		restoreOk = 1'b1;
		selfTest = '0;
		resetTest();
		coldStartupTest();
		shutdownTrafficTest();
		selfTestTest();
		orderlyTest();
		failedRestoreTest();
		$display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount,
			errorCount);
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/clockGen.sv
// testbench clock and reset_n generator, with a request input for later resets
`default_nettype none

module clockGen #(
	parameter real period = 4.0,
	parameter int resetCycles = 3
) (
	input  wire  resetRequest,
	output logic clock,
	output logic reset_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #(period / 2.0) clock = ~clock;
	end

	// low for resetCycles rising edges at power-on and after each request
	initial begin
		reset_n = 1'b0;
		forever begin
			repeat (resetCycles) @(posedge clock);
			reset_n <= 1'b1; // released on a rising edge
			wait (resetRequest);
			@(negedge clock);
			reset_n <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/tpmManagement.sv
// TPM management top level joining lifecycle FSM, startup counters and restore policy
`default_nettype none

module tpmManagement #(
	parameter int unsigned           counterWidth  = 32,
	parameter tpmMgmtPkg::testCountT fullTestCount = 16'd40
) (
	input  wire                             clock,
	input  wire                             reset_n,
	input  wire tpmMgmtPkg::commandT        command,
	input  wire                             commandValid,
	output logic                            commandReady,
	input  wire                             orderlyAtPowerOn,
	input  wire                             restoreOk,
	input  wire tpmMgmtPkg::selfTestStatusT selfTest,
	output tpmMgmtPkg::opStateT             opState,
	output logic                            shutdownSave,
	output logic [counterWidth-1:0]         resetCount,
	output logic [counterWidth-1:0]         restartCount,
	output logic [counterWidth-1:0]         clearCount,
	output tpmMgmtPkg::hierarchyT           hierarchy,
	output tpmMgmtPkg::restoreSelectT       selects,
	output logic                            initialized
);

	tpmMgmtPkg::startupEventT startupEvent; // FSM to counters and policy

	lifecycleFsm #(.fullTestCount(fullTestCount)) fsm (
		.clock(clock),
		.reset_n(reset_n),
		.command(command),
		.commandValid(commandValid),
		.commandReady(commandReady),
		.orderlyAtPowerOn(orderlyAtPowerOn),
		.restoreOk(restoreOk),
		.selfTest(selfTest),
		.opState(opState),
		.startupEvent(startupEvent),
		.shutdownSave(shutdownSave)
	);

	startupCounters #(.counterWidth(counterWidth)) counters (
		.clock(clock),
		.reset_n(reset_n),
		.startupEvent(startupEvent),
		.resetCount(resetCount),
		.restartCount(restartCount),
		.clearCount(clearCount)
	);

	restorePolicy policy (
		.clock(clock),
		.reset_n(reset_n),
		.startupEvent(startupEvent),
		.hierarchy(hierarchy),
		.selects(selects),
		.initialized(initialized)
	);

endmodule

`default_nettype wire

//--- hw/restorePolicy.sv
// hierarchy enables, preserve/default selects, initialized flag and secret regeneration pulse
`default_nettype none

module restorePolicy (
	input  wire                            clock,
	input  wire                            reset_n,
	input  wire tpmMgmtPkg::startupEventT  startupEvent,
	output tpmMgmtPkg::hierarchyT          hierarchy,
	output tpmMgmtPkg::restoreSelectT      selects,
	output logic                           initialized
);

	// select set for one startup kind
	function automatic tpmMgmtPkg::restoreSelectT selectsFor(tpmMgmtPkg::startupKindT kind);
		tpmMgmtPkg::restoreSelectT s;
		s = '{platformAuth: 1'b1, nvIndex: 1'b1, pcrSave: tpmMgmtPkg::psPreserved,
			contextArray: 1'b1, audit: 1'b1, commit: 1'b1, act: 1'b1,
			regenerateSecrets: 1'b0}; // resume keeps everything
		case (kind)
			tpmMgmtPkg::tpmReset: begin
				s = '0;
				s.pcrSave = tpmMgmtPkg::fullDefault;
				s.regenerateSecrets = 1'b1;
			end
			tpmMgmtPkg::tpmRestart: begin
				s.platformAuth = 1'b0;
				s.nvIndex = 1'b0;
				s.act = 1'b0;
				s.pcrSave = tpmMgmtPkg::fullDefault;
			end
			default: s.pcrSave = tpmMgmtPkg::psPreserved;
		endcase
		return s;
	endfunction

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			hierarchy <= '0;
			initialized <= 1'b0;
			selects <= '{platformAuth: 1'b1, nvIndex: 1'b1, pcrSave: tpmMgmtPkg::fullPreserved,
				contextArray: 1'b1, audit: 1'b1, commit: 1'b1, act: 1'b1,
				regenerateSecrets: 1'b0};
		end else if (startupEvent.fire) begin
			selects <= selectsFor(startupEvent.kind);
			initialized <= 1'b1;
			hierarchy.platform <= 1'b1;
			if (startupEvent.kind != tpmMgmtPkg::tpmResume) begin
				hierarchy.platformNv <= 1'b1;
				hierarchy.owner <= 1'b1;
				hierarchy.endorsement <= 1'b1;
			end
		end else begin
			selects.regenerateSecrets <= 1'b0; // pulse ends, other selects hold
		end
	end

	// secrets are regenerated once per Reset, never on back-to-back cycles
	regenerateIsPulse: assert property (@(posedge clock) disable iff (!reset_n)
		selects.regenerateSecrets |=> !selects.regenerateSecrets);

endmodule

`default_nettype wire

//--- hw/startupCounters.sv
// reset, restart and clear counters advanced on startup events
`default_nettype none

module startupCounters #(
	parameter int unsigned counterWidth = 32
) (
	input  wire                            clock,
	input  wire                            reset_n,
	input  wire tpmMgmtPkg::startupEventT  startupEvent,
	output logic [counterWidth-1:0]        resetCount,
	output logic [counterWidth-1:0]        restartCount,
	output logic [counterWidth-1:0]        clearCount
);

	localparam logic [counterWidth-1:0] one = counterWidth'(1);

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			resetCount <= '0;
			restartCount <= '0;
			clearCount <= '0;
		end else if (startupEvent.fire) begin
			case (startupEvent.kind)
				tpmMgmtPkg::tpmReset: begin
					resetCount <= resetCount + one;
					restartCount <= '0;
					clearCount <= '0;
				end
				tpmMgmtPkg::tpmRestart: begin
					restartCount <= restartCount + one;
					clearCount <= clearCount + one;
				end
				tpmMgmtPkg::tpmResume: begin
					restartCount <= restartCount + one; // clear count holds
				end
				default: begin
					resetCount <= resetCount;
				end
			endcase
		end
	end

	// the FSM only fires with a decoded startup kind
	fireHasKind: assert property (@(posedge clock) disable iff (!reset_n)
		startupEvent.fire |-> startupEvent.kind != tpmMgmtPkg::startupKindT'(2'd0));

endmodule

`default_nettype wire

//--- hw/lifecycleFsm.sv
// operational-state FSM with command handshake, startup decode, orderly and shutdown records
`default_nettype none

module lifecycleFsm #(
	parameter tpmMgmtPkg::testCountT fullTestCount = 16'd40
) (
	input  wire                        clock,
	input  wire                        reset_n,
	input  wire tpmMgmtPkg::commandT   command,
	input  wire                        commandValid,
	output logic                       commandReady,
	input  wire                        orderlyAtPowerOn,
	input  wire                        restoreOk,
	input  wire tpmMgmtPkg::selfTestStatusT selfTest,
	output tpmMgmtPkg::opStateT        opState,
	output tpmMgmtPkg::startupEventT   startupEvent,
	output logic                       shutdownSave
);

	tpmMgmtPkg::opStateT     nextState;
	tpmMgmtPkg::startupKindT startupKind;
	logic accept;
	logic paramBit; // param of the last accepted command
	logic orderly;

	assign commandReady = (opState == tpmMgmtPkg::initialization) ||
		(opState == tpmMgmtPkg::operational) || (opState == tpmMgmtPkg::failureMode);
	assign accept = commandValid && commandReady;

	// startup outcome, only meaningful while in startup
	always_comb begin
		startupKind = tpmMgmtPkg::startupKindT'(2'd0);
		if (opState == tpmMgmtPkg::startup) begin
			if (!orderly) begin
				if (paramBit == tpmMgmtPkg::suClear)
					startupKind = tpmMgmtPkg::tpmReset;
			end else if (paramBit == tpmMgmtPkg::suClear) begin
				startupKind = tpmMgmtPkg::tpmRestart;
			end else if (restoreOk) begin
				startupKind = tpmMgmtPkg::tpmResume;
			end
		end
	end

	assign startupEvent = '{fire: (startupKind != tpmMgmtPkg::startupKindT'(2'd0)),
		kind: startupKind};

	always_comb begin
		nextState = opState;
		case (opState)
			tpmMgmtPkg::powerOff: nextState = tpmMgmtPkg::initialization;
			tpmMgmtPkg::initialization: begin
				if (accept && command.code == tpmMgmtPkg::ccStartup)
					nextState = tpmMgmtPkg::startup;
			end
			tpmMgmtPkg::startup: begin
				if (startupEvent.fire)
					nextState = tpmMgmtPkg::operational;
				else if (orderly)
					nextState = tpmMgmtPkg::failureMode; // state restore failed
				else
					nextState = tpmMgmtPkg::initialization; // SU_STATE after a cold power-on
			end
			tpmMgmtPkg::operational: begin
				if (accept && (command.code == tpmMgmtPkg::ccSelfTest ||
						command.code == tpmMgmtPkg::ccIncrementalSelfTest))
					nextState = tpmMgmtPkg::selfTest;
				else if (accept && command.code == tpmMgmtPkg::ccShutdown)
					nextState = tpmMgmtPkg::shutdown;
			end
			tpmMgmtPkg::selfTest: begin
				if (selfTest.testsPassed != selfTest.testsRun)
					nextState = tpmMgmtPkg::failureMode;
				else if (paramBit && selfTest.testsPassed == fullTestCount)
					nextState = tpmMgmtPkg::operational; // full test complete
				else if (!paramBit && selfTest.untested == '0)
					nextState = tpmMgmtPkg::operational;
			end
			tpmMgmtPkg::shutdown: nextState = tpmMgmtPkg::operational;
			default: nextState = tpmMgmtPkg::failureMode; // failure mode is absorbing
		endcase
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			opState <= tpmMgmtPkg::powerOff;
			orderly <= 1'b0;
			shutdownSave <= 1'b0;
		end else begin
			opState <= nextState;
			if (opState == tpmMgmtPkg::powerOff) begin
				orderly <= orderlyAtPowerOn;
			end else if (opState == tpmMgmtPkg::shutdown) begin
				orderly <= 1'b1;
				shutdownSave <= paramBit;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			paramBit <= command.param;
	end

	// nothing may be taken while a startup, self-test or shutdown is in flight
	busyNotReady: assert property (@(posedge clock) disable iff (!reset_n)
		(opState inside {tpmMgmtPkg::startup, tpmMgmtPkg::selfTest, tpmMgmtPkg::shutdown})
		|-> !commandReady);

endmodule

`default_nettype wire

//--- hw/tpmMgmtPkg.sv
// command codes, count widths, lifecycle enums and the structs shared by the TPM manager
`default_nettype none

package tpmMgmtPkg;

	typedef logic [31:0] commandCodeT;

	localparam commandCodeT ccIncrementalSelfTest = 32'h0000_0142;
	localparam commandCodeT ccSelfTest            = 32'h0000_0143;
	localparam commandCodeT ccStartup             = 32'h0000_0144;
	localparam commandCodeT ccShutdown            = 32'h0000_0145;

	// startup / shutdown type carried in the param bit
	localparam logic suClear = 1'b0;
	localparam logic suState = 1'b1;

	typedef struct packed {
		commandCodeT code;
		logic        param; // su type, or fullTest for self-test
	} commandT;

	typedef logic [15:0] testCountT;

	typedef struct packed {
		testCountT testsRun;
		testCountT testsPassed;
		testCountT untested;
	} selfTestStatusT;

	typedef enum logic [2:0] {
		powerOff       = 3'd0,
		initialization = 3'd1,
		startup        = 3'd2,
		operational    = 3'd3,
		selfTest       = 3'd4,
		failureMode    = 3'd5,
		shutdown       = 3'd6
	} opStateT;

	// 0 is left unused, it marks "no startup"
	typedef enum logic [1:0] {
		tpmReset   = 2'd1,
		tpmRestart = 2'd2,
		tpmResume  = 2'd3
	} startupKindT;

	typedef struct packed {
		logic        fire; // one cycle, in the startup state
		startupKindT kind;
	} startupEventT;

	typedef enum logic [1:0] {
		fullDefault   = 2'd0,
		psPreserved   = 2'd1,
		fullPreserved = 2'd2
	} pcrSaveT;

	typedef struct packed {
		logic platform;
		logic platformNv;
		logic owner;
		logic endorsement;
	} hierarchyT;

	// 1 = preserved, 0 = default
	typedef struct packed {
		logic    platformAuth;
		logic    nvIndex;
		pcrSaveT pcrSave;
		logic    contextArray; // saved session contexts
		logic    audit;
		logic    commit;
		logic    act;
		logic    regenerateSecrets; // null proof/seed, context key, commit nonce
	} restoreSelectT;

endpackage

`default_nettype wire
